//--- Bender.yml
package:
  name: trace_encoder

sources:
  # package first, then the pipeline stages and the top level
  - src/trace_pkg.sv
  - src/trace_sampler.sv
  - src/trace_itype_stage.sv
  - src/trace_branch_map.sv
  - src/trace_packet_decider.sv
  - src/trace_packet_emitter.sv
  - src/trace_encoder.sv
  - target: test
    files:
      - test/trace_encoder_tb.sv

//--- src/trace_branch_map.sv
// ##########################################################################
// branch outcome map with branch count, full detection and flush
// ##########################################################################

`timescale 1ns/1ns

module trace_branch_map (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     record_i,
    input  logic                     taken_i,
    input  logic                     flush_i,
    output trace_pkg::branch_map_t   map_o,
    output trace_pkg::branch_count_t count_o,
    output logic                     full_o
);
    import trace_pkg::*;

    branch_map_t   map_q;
    branch_count_t count_q;
    logic          full;

    assign full = (count_q == branch_count_t'(BRANCH_MAP_LEN));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // a branch recorded with the flush starts the new map
            map_q   <= record_i ? branch_map_t'(!taken_i) : '0;
            count_q <= record_i ? branch_count_t'(1) : '0;
        end else if (record_i) begin
            // stored as not-taken bit
            map_q[count_q] <= !taken_i;
            count_q        <= count_q + branch_count_t'(1);
        end
    end

    assign map_o   = map_q;
    assign count_o = count_q;
    assign full_o  = full;

    // the decider reports a full map before another branch comes in
    a_no_record_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (record_i && full) |-> flush_i);

endmodule

//--- src/trace_encoder.sv
// ##########################################################################
// trace encoder top: sampler, itype stage, branch map,
// packet decider and packet emitter
// ##########################################################################

`timescale 1ns/1ns

module trace_encoder (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       inst_valid_i,
    input  trace_pkg::addr_t           pc_i,
    input  trace_pkg::inst_t           inst_data_i,
    input  logic                       exception_i,
    input  logic                       interrupt_i,
    input  trace_pkg::cause_t          cause_i,
    input  logic                       trace_enable_i,
    output logic                       inst_ready_o,
    output logic                       packet_valid_o,
    output trace_pkg::packet_format_e  packet_format_o,
    output trace_pkg::sync_subformat_e packet_subformat_o,
    output trace_pkg::payload_t        packet_payload_o,
    input  logic                       packet_ready_i
);
    import trace_pkg::*;

    // handshake between the stages
    logic            advance;
    logic            emit_ready;
    logic            emit;
    // phase outputs of the sampler
    logic            nc_valid;
    addr_t           nc_pc;
    inst_t           nc_inst;
    logic            tc_valid;
    logic            tc_qualified;
    addr_t           tc_pc;
    logic            lc_qualified;
    logic            lc_exception;
    cause_t          lc_cause;
    logic            lc_interrupt;
    // type flags
    logic            tc_branch;
    logic            tc_branch_taken;
    logic            lc_updiscon;
    // branch map
    logic            record;
    logic            flush;
    branch_map_t     map;
    branch_count_t   count;
    // decided packet
    packet_format_e  format;
    sync_subformat_e subformat;
    payload_t        payload;

    trace_sampler i_sampler (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .inst_valid_i   (inst_valid_i),
        .pc_i           (pc_i),
        .inst_data_i    (inst_data_i),
        .exception_i    (exception_i),
        .interrupt_i    (interrupt_i),
        .cause_i        (cause_i),
        .trace_enable_i (trace_enable_i),
        .emit_ready_i   (emit_ready),
        .inst_ready_o   (inst_ready_o),
        .advance_o      (advance),
        .nc_valid_o     (nc_valid),
        .nc_pc_o        (nc_pc),
        .nc_inst_o      (nc_inst),
        .tc_valid_o     (tc_valid),
        .tc_qualified_o (tc_qualified),
        .tc_pc_o        (tc_pc),
        // tc cause and irq only feed the lc phase
        .tc_interrupt_o (),
        .tc_cause_o     (),
        .lc_qualified_o (lc_qualified),
        .lc_exception_o (lc_exception),
        .lc_cause_o     (lc_cause),
        .lc_interrupt_o (lc_interrupt)
    );

    trace_itype_stage i_itype_stage (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .advance_i         (advance),
        .nc_valid_i        (nc_valid),
        .nc_inst_i         (nc_inst),
        .nc_pc_i           (nc_pc),
        .tc_pc_i           (tc_pc),
        .tc_valid_i        (tc_valid),
        .tc_branch_o       (tc_branch),
        .tc_branch_taken_o (tc_branch_taken),
        .lc_updiscon_o     (lc_updiscon)
    );

    // full map is reported by the decider from the effective count
    trace_branch_map i_branch_map (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .record_i (record),
        .taken_i  (tc_branch_taken),
        .flush_i  (flush),
        .map_o    (map),
        .count_o  (count),
        .full_o   ()
    );

    trace_packet_decider i_decider (
        .advance_i         (advance),
        .tc_valid_i        (tc_valid),
        .tc_qualified_i    (tc_qualified),
        .lc_qualified_i    (lc_qualified),
        .lc_exception_i    (lc_exception),
        .lc_updiscon_i     (lc_updiscon),
        .tc_branch_i       (tc_branch),
        .tc_branch_taken_i (tc_branch_taken),
        .tc_pc_i           (tc_pc),
        .lc_cause_i        (lc_cause),
        .lc_interrupt_i    (lc_interrupt),
        .map_i             (map),
        .count_i           (count),
        .emit_o            (emit),
        .format_o          (format),
        .subformat_o       (subformat),
        .payload_o         (payload),
        .record_o          (record),
        .flush_o           (flush)
    );

    trace_packet_emitter i_emitter (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .load_i             (emit),
        .format_i           (format),
        .subformat_i        (subformat),
        .payload_i          (payload),
        .packet_ready_i     (packet_ready_i),
        .emit_ready_o       (emit_ready),
        .packet_valid_o     (packet_valid_o),
        .packet_format_o    (packet_format_o),
        .packet_subformat_o (packet_subformat_o),
        .packet_payload_o   (packet_payload_o)
    );

endmodule

//--- src/trace_itype_stage.sv
// ##########################################################################
// instruction type decode and per-phase branch / discontinuity flags
// ##########################################################################

`timescale 1ns/1ns

module trace_itype_stage (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             advance_i,
    input  logic             nc_valid_i,
    input  trace_pkg::inst_t nc_inst_i,
    input  trace_pkg::addr_t nc_pc_i,
    input  trace_pkg::addr_t tc_pc_i,
    input  logic             tc_valid_i,
    output logic             tc_branch_o,
    output logic             tc_branch_taken_o,
    output logic             lc_updiscon_o
);
    import trace_pkg::*;

    logic  nc_branch;
    logic  nc_updiscon;
    logic  tc_branch_q;
    logic  tc_updiscon_q;
    logic  lc_updiscon_q;
    addr_t tc_next_pc;

    // conditional branch in nc
    assign nc_branch = nc_valid_i && (nc_inst_i[6:0] == OPCODE_BRANCH);
    // target not inferable from the binary: jalr or mret
    assign nc_updiscon = nc_valid_i &&
                         ((nc_inst_i[6:0] == OPCODE_JALR) || (nc_inst_i == INST_MRET));

    // flags travel with the phase registers
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tc_branch_q   <= 1'b0;
            tc_updiscon_q <= 1'b0;
            lc_updiscon_q <= 1'b0;
        end else if (advance_i) begin
            tc_branch_q   <= nc_branch;
            tc_updiscon_q <= nc_updiscon;
            lc_updiscon_q <= tc_updiscon_q;
        end
    end

    // sequential successor of tc, compressed code not supported
    assign tc_next_pc = tc_pc_i + addr_t'(4);

    assign tc_branch_o = tc_valid_i && tc_branch_q;
    // taken when the successor in nc is not the fall-through address
    assign tc_branch_taken_o = tc_branch_o && (nc_pc_i != tc_next_pc);
    assign lc_updiscon_o     = lc_updiscon_q;

endmodule

//--- src/trace_packet_decider.sv
// ##########################################################################
// packet priority rules for the tc instruction, packet fields
// and the branch map record / flush strobes
// ##########################################################################

`timescale 1ns/1ns

module trace_packet_decider (
    input  logic                       advance_i,
    input  logic                       tc_valid_i,
    input  logic                       tc_qualified_i,
    input  logic                       lc_qualified_i,
    input  logic                       lc_exception_i,
    input  logic                       lc_updiscon_i,
    input  logic                       tc_branch_i,
    input  logic                       tc_branch_taken_i,
    input  trace_pkg::addr_t           tc_pc_i,
    input  trace_pkg::cause_t          lc_cause_i,
    input  logic                       lc_interrupt_i,
    input  trace_pkg::branch_map_t     map_i,
    input  trace_pkg::branch_count_t   count_i,
    output logic                       emit_o,
    output trace_pkg::packet_format_e  format_o,
    output trace_pkg::sync_subformat_e subformat_o,
    output trace_pkg::payload_t        payload_o,
    output logic                       record_o,
    output logic                       flush_o
);
    import trace_pkg::*;

    logic          qual_tc;
    logic          report_map;
    branch_count_t eff_count;
    branch_map_t   eff_map;

    // tc is final and traced
    assign qual_tc = advance_i && tc_valid_i && tc_qualified_i;

    // stored map plus the tc branch itself
    assign eff_count = count_i + branch_count_t'(tc_branch_i);
    assign eff_map   = map_i | (branch_map_t'(tc_branch_i && !tc_branch_taken_i) << count_i);

    always_comb begin
        emit_o      = 1'b0;
        report_map  = 1'b0;
        format_o    = F_SYNC;
        subformat_o = SF_START;
        payload_o   = '0;
        if (qual_tc) begin
            if (!lc_qualified_i) begin
                // first traced instruction
                emit_o = 1'b1;
            end else if (lc_exception_i) begin
                // tc is the handler, pending branches dropped
                emit_o      = 1'b1;
                subformat_o = SF_TRAP;
                payload_o[PL_COUNT_LSB +: CAUSE_LEN] = lc_cause_i;
                payload_o[PL_IRQ_BIT]                = lc_interrupt_i;
            end else if (lc_updiscon_i && (eff_count == '0)) begin
                emit_o   = 1'b1;
                format_o = F_ADDR_ONLY;
            end else if (lc_updiscon_i || (eff_count == branch_count_t'(BRANCH_MAP_LEN))) begin
                // discontinuity with branches, or map full
                emit_o     = 1'b1;
                report_map = 1'b1;
                format_o   = F_BRANCH_FULL;
            end
        end
        if (emit_o) begin
            payload_o[PL_ADDR_LSB +: XLEN] = tc_pc_i;
        end
        if (report_map) begin
            payload_o[PL_COUNT_LSB +: BRANCH_COUNT_LEN] = eff_count;
            payload_o[PL_MAP_LSB +: BRANCH_MAP_LEN]     = eff_map;
        end
    end

    // the tc branch goes in the map unless this packet reports it already
    assign record_o = qual_tc && tc_branch_i && !report_map;
    // every packet starts a fresh map
    assign flush_o  = emit_o;

endmodule

//--- src/trace_packet_emitter.sv
// ##########################################################################
// output packet register with valid/ready hold under back-pressure
// ##########################################################################

`timescale 1ns/1ns

module trace_packet_emitter (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       load_i,
    input  trace_pkg::packet_format_e  format_i,
    input  trace_pkg::sync_subformat_e subformat_i,
    input  trace_pkg::payload_t        payload_i,
    input  logic                       packet_ready_i,
    output logic                       emit_ready_o,
    output logic                       packet_valid_o,
    output trace_pkg::packet_format_e  packet_format_o,
    output trace_pkg::sync_subformat_e packet_subformat_o,
    output trace_pkg::payload_t        packet_payload_o
);
    import trace_pkg::*;

    logic            valid_q;
    packet_format_e  format_q;
    sync_subformat_e subformat_q;
    payload_t        payload_q;

    // free slot, or the held packet leaves this cycle
    assign emit_ready_o = !valid_q || packet_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;
        end else if (packet_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            format_q    <= format_i;
            subformat_q <= subformat_i;
            payload_q   <= payload_i;
        end
    end

    assign packet_valid_o     = valid_q;
    assign packet_format_o    = format_q;
    assign packet_subformat_o = subformat_q;
    assign packet_payload_o   = payload_q;

    // a stalled packet stays put until taken
    a_hold_when_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_q && !packet_ready_i) |=> (valid_q && $stable(format_q) &&
                                          $stable(subformat_q) && $stable(payload_q)));

endmodule

//--- src/trace_pkg.sv
// ##########################################################################
// shared widths, vector types, payload field positions, opcodes
// and the packet format / sync subformat enums of the trace encoder
// ##########################################################################

package trace_pkg;

    // widths
    localparam int XLEN             = 32;
    localparam int INST_LEN         = 32;
    localparam int CAUSE_LEN        = 5;
    localparam int BRANCH_MAP_LEN   = 31;
    localparam int BRANCH_COUNT_LEN = 5;
    localparam int PAYLOAD_LEN      = 72;

    typedef logic [XLEN-1:0]             addr_t;
    typedef logic [INST_LEN-1:0]         inst_t;
    typedef logic [CAUSE_LEN-1:0]        cause_t;
    // bit i set means the i-th branch was not taken
    typedef logic [BRANCH_MAP_LEN-1:0]   branch_map_t;
    typedef logic [BRANCH_COUNT_LEN-1:0] branch_count_t;
    typedef logic [PAYLOAD_LEN-1:0]      payload_t;

    // payload layout, unused bits stay zero
    localparam int PL_ADDR_LSB  = 0;
    // branch count, or cause in a trap packet
    localparam int PL_COUNT_LSB = 32;
    // map in format 1, irq flag in trap packets
    localparam int PL_MAP_LSB   = 37;
    localparam int PL_IRQ_BIT   = 37;

    // opcodes of interest
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam inst_t      INST_MRET     = 32'h3020_0073;

    typedef enum logic [1:0] {
        F_BRANCH_FULL = 2'd1,
        F_ADDR_ONLY   = 2'd2,
        F_SYNC        = 2'd3
    } packet_format_e;

    typedef enum logic [1:0] {
        SF_START = 2'd0,
        SF_TRAP  = 2'd1
    } sync_subformat_e;

endpackage

//--- src/trace_sampler.sv
// ##########################################################################
// input handshake and nc/tc/lc shift registers of retired instructions
// ##########################################################################

`timescale 1ns/1ns

module trace_sampler (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              inst_valid_i,
    input  trace_pkg::addr_t  pc_i,
    input  trace_pkg::inst_t  inst_data_i,
    input  logic              exception_i,
    input  logic              interrupt_i,
    input  trace_pkg::cause_t cause_i,
    input  logic              trace_enable_i,
    input  logic              emit_ready_i,
    output logic              inst_ready_o,
    output logic              advance_o,
    output logic              nc_valid_o,
    output trace_pkg::addr_t  nc_pc_o,
    output trace_pkg::inst_t  nc_inst_o,
    output logic              tc_valid_o,
    output logic              tc_qualified_o,
    output trace_pkg::addr_t  tc_pc_o,
    output logic              tc_interrupt_o,
    output trace_pkg::cause_t tc_cause_o,
    output logic              lc_qualified_o,
    output logic              lc_exception_o,
    output trace_pkg::cause_t lc_cause_o,
    output logic              lc_interrupt_o
);
    import trace_pkg::*;

    // next cycle phase
    logic   nc_valid_q;
    logic   nc_qualified_q;
    logic   nc_exception_q;
    logic   nc_interrupt_q;
    addr_t  nc_pc_q;
    inst_t  nc_inst_q;
    cause_t nc_cause_q;
    // this cycle phase
    logic   tc_valid_q;
    logic   tc_qualified_q;
    logic   tc_exception_q;
    logic   tc_interrupt_q;
    addr_t  tc_pc_q;
    cause_t tc_cause_q;
    // last cycle phase
    logic   lc_qualified_q;
    logic   lc_exception_q;
    logic   lc_interrupt_q;
    cause_t lc_cause_q;

    // accept only when the emitter can take a packet
    assign inst_ready_o = emit_ready_i;
    assign advance_o    = inst_valid_i && emit_ready_i;

    // control bits of all three phases
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            nc_valid_q     <= 1'b0;
            nc_qualified_q <= 1'b0;
            nc_exception_q <= 1'b0;
            tc_valid_q     <= 1'b0;
            tc_qualified_q <= 1'b0;
            tc_exception_q <= 1'b0;
            lc_qualified_q <= 1'b0;
            lc_exception_q <= 1'b0;
        end else if (advance_o) begin
            nc_valid_q     <= 1'b1;
            nc_qualified_q <= trace_enable_i;
            nc_exception_q <= exception_i;
            tc_valid_q     <= nc_valid_q;
            tc_qualified_q <= nc_qualified_q;
            tc_exception_q <= nc_exception_q;
            lc_qualified_q <= tc_qualified_q;
            lc_exception_q <= tc_exception_q;
        end
    end

    // payload of the phases, only meaningful behind a valid bit
    always_ff @(posedge clk_i) begin
        if (advance_o) begin
            nc_pc_q        <= pc_i;
            nc_inst_q      <= inst_data_i;
            nc_interrupt_q <= interrupt_i;
            nc_cause_q     <= cause_i;
            tc_pc_q        <= nc_pc_q;
            tc_interrupt_q <= nc_interrupt_q;
            tc_cause_q     <= nc_cause_q;
            lc_interrupt_q <= tc_interrupt_q;
            lc_cause_q     <= tc_cause_q;
        end
    end

    assign nc_valid_o     = nc_valid_q;
    assign nc_pc_o        = nc_pc_q;
    assign nc_inst_o      = nc_inst_q;
    assign tc_valid_o     = tc_valid_q;
    assign tc_qualified_o = tc_qualified_q;
    assign tc_pc_o        = tc_pc_q;
    assign tc_interrupt_o = tc_interrupt_q;
    assign tc_cause_o     = tc_cause_q;
    assign lc_qualified_o = lc_qualified_q;
    assign lc_exception_o = lc_exception_q;
    assign lc_cause_o     = lc_cause_q;
    assign lc_interrupt_o = lc_interrupt_q;

    // an offered instruction stays put until it is taken
    a_input_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (inst_valid_i && !inst_ready_o) |=> (inst_valid_i && $stable(pc_i) &&
                                             $stable(inst_data_i) && $stable(exception_i) &&
                                             $stable(interrupt_i) && $stable(cause_i) &&
                                             $stable(trace_enable_i)));

endmodule

//--- test/trace_encoder_tb.sv
// ##########################################################################
// testbench of the trace encoder: clock, reset, stimulus file reader,
// instruction driver, random packet ready, packet checker and watchdog
// ##########################################################################

`timescale 1ns/1ns

module trace_encoder_tb;
    import trace_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 16;
    localparam int CYCLES_PER_REC = 50;
    localparam int DRIVE_DELAY    = 1;

    logic            clk_i;
    logic            rst_ni;
    logic            inst_valid_i;
    addr_t           pc_i;
    inst_t           inst_data_i;
    logic            exception_i;
    logic            interrupt_i;
    cause_t          cause_i;
    logic            trace_enable_i;
    logic            inst_ready_o;
    logic            packet_valid_o;
    packet_format_e  packet_format_o;
    sync_subformat_e packet_subformat_o;
    payload_t        packet_payload_o;
    logic            packet_ready_i;

    // one entry per retired instruction, repeats already expanded
    addr_t    stim_pc[$];
    inst_t    stim_inst[$];
    logic     stim_exc[$];
    logic     stim_irq[$];
    cause_t   stim_cause[$];
    logic     stim_en[$];
    // expected packets in order
    string    exp_name[$];
    int       exp_format[$];
    int       exp_subformat[$];
    payload_t exp_payload[$];

    integer   seed = 32'ha5aa;
    integer   rnd;
    logic     stim_loaded = 1'b0;
    int       checked = 0;

    trace_encoder UUT (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .inst_valid_i       (inst_valid_i),
        .pc_i               (pc_i),
        .inst_data_i        (inst_data_i),
        .exception_i        (exception_i),
        .interrupt_i        (interrupt_i),
        .cause_i            (cause_i),
        .trace_enable_i     (trace_enable_i),
        .inst_ready_o       (inst_ready_o),
        .packet_valid_o     (packet_valid_o),
        .packet_format_o    (packet_format_o),
        .packet_subformat_o (packet_subformat_o),
        .packet_payload_o   (packet_payload_o),
        .packet_ready_i     (packet_ready_i)
    );

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic load_stimulus();
        int       fd;
        int       fields;
        int       i;
        int       exc;
        int       irq;
        int       en;
        int       rep;
        int       fmt;
        int       sub;
        string    line;
        string    name;
        addr_t    pc;
        inst_t    inst;
        cause_t   cause;
        payload_t payload;
        fd = $fopen("test/trace_stim.txt", "r");
        assert (fd != 0) else
            stop_with_failure("cannot open the stimulus file test/trace_stim.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.getc(0) == "I") begin
                fields = $sscanf(line, "I %h %h %d %d %h %d %d",
                                 pc, inst, exc, irq, cause, en, rep);
                assert (fields == 7) else
                    stop_with_failure({"malformed instruction record: ", line});
                // a repeated record runs straight-line, pc steps by 4
                for (i = 0; i < rep; i++) begin
                    stim_pc.push_back(pc);
                    stim_inst.push_back(inst);
                    stim_exc.push_back(exc[0]);
                    stim_irq.push_back(irq[0]);
                    stim_cause.push_back(cause);
                    stim_en.push_back(en[0]);
                    pc = pc + addr_t'(4);
                end
            end else if (line.getc(0) == "P") begin
                fields = $sscanf(line, "P %s %d %d %h", name, fmt, sub, payload);
                assert (fields == 4) else
                    stop_with_failure({"malformed packet record: ", line});
                exp_name.push_back(name);
                exp_format.push_back(fmt);
                exp_subformat.push_back(sub);
                exp_payload.push_back(payload);
            end
        end
        $fclose(fd);
    endtask

    // called a small delay after a rising edge, returns the same way
    task automatic drive_instruction(input int idx);
        logic accepted;
        inst_valid_i   = 1'b1;
        pc_i           = stim_pc[idx];
        inst_data_i    = stim_inst[idx];
        exception_i    = stim_exc[idx];
        interrupt_i    = stim_irq[idx];
        cause_i        = stim_cause[idx];
        trace_enable_i = stim_en[idx];
        accepted       = 1'b0;
        // ready seen at the falling edge means a transfer on the next rise
        while (!accepted) begin
            @(negedge clk_i);
            accepted = inst_ready_o;
            @(posedge clk_i);
        end
        #DRIVE_DELAY;
    endtask

    task automatic check_packet();
        string    name;
        int       fmt;
        int       sub;
        payload_t payload;
        assert (exp_name.size() > 0) else
            stop_with_failure("the DUT sent a packet that no expected record covers");
        name    = exp_name.pop_front();
        fmt     = exp_format.pop_front();
        sub     = exp_subformat.pop_front();
        payload = exp_payload.pop_front();
        assert (int'(packet_format_o) == fmt) else
            stop_with_failure($sformatf("Mismatch %s format: expected %0d, actual %0d",
                                        name, fmt, packet_format_o));
        assert (int'(packet_subformat_o) == sub) else
            stop_with_failure($sformatf("Mismatch %s subformat: expected %0d, actual %0d",
                                        name, sub, packet_subformat_o));
        assert (packet_payload_o == payload) else
            stop_with_failure($sformatf("Mismatch %s payload: expected %h, actual %h",
                                        name, payload, packet_payload_o));
        checked++;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // random sink ready, changed just after each rising edge
    initial begin
        @(posedge rst_ni);
        forever begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            rnd            = $random(seed);
            packet_ready_i = rnd[0];
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (rst_ni) begin
            // a stalled packet must stop the input side
            assert (inst_ready_o == (!packet_valid_o || packet_ready_i)) else
                stop_with_failure("inst_ready_o does not follow the packet handshake");
            if (packet_valid_o && packet_ready_i) begin
                check_packet();
            end
        end
    end

    // budget grows with the number of records
    initial begin
        longint limit_ns;
        wait (stim_loaded);
        limit_ns = longint'(RESET_CYCLES + CYCLES_PER_REC *
                            (stim_pc.size() + exp_name.size())) * CLK_PERIOD;
        #(limit_ns);
        stop_with_failure($sformatf("timeout: the run did not finish within %0d ns",
                                    limit_ns));
    end

    initial begin
        rst_ni         = 1'b0;
        inst_valid_i   = 1'b0;
        pc_i           = '0;
        inst_data_i    = '0;
        exception_i    = 1'b0;
        interrupt_i    = 1'b0;
        cause_i        = '0;
        trace_enable_i = 1'b0;
        packet_ready_i = 1'b0;
        load_stimulus();
        stim_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_ni = 1'b1;
        @(posedge clk_i);
        #DRIVE_DELAY;
        for (int idx = 0; idx < stim_pc.size(); idx++) begin
            drive_instruction(idx);
        end
        inst_valid_i = 1'b0;
        // let the last packet drain
        @(negedge clk_i);
        while (packet_valid_o) begin
            @(negedge clk_i);
        end
        assert (exp_name.size() == 0) begin
            $display("%0d packets checked", checked);
            $display("Everything OK");
            $finish;
        end else begin
            stop_with_failure($sformatf("%0d expected packets never arrived",
                                        exp_name.size()));
        end
    end

endmodule

//--- test/trace_stim.txt
# I pc inst exception interrupt cause enable repeat  (pc, inst, cause in hex; repeat steps pc by 4)
# P test_name format subformat payload               (payload in hex, 72 bits)

# first traced instruction, then a fault into the handler at 0x800
I 00000100 00000013 0 0 00 1 1
I 00000104 00000013 0 0 00 1 1
I 00000108 00000013 1 0 05 1 1
I 00000800 00000013 0 0 00 1 1
P start_first 3 0 000000000000000100
P trap_exception 3 1 000000000500000800

# jalr with no pending branches
I 00000804 00008067 0 0 00 1 1
I 00000200 00000013 0 0 00 1 1
P jalr_no_branches 2 0 000000000000000200

# not taken, taken, not taken, then mret to 0x400
I 00000204 00208463 0 0 00 1 1
I 00000208 00208463 0 0 00 1 1
I 00000300 00208463 0 0 00 1 1
I 00000304 30200073 0 0 00 1 1
I 00000400 00000013 0 0 00 1 1
P mret_branch_map 1 0 00000000a300000400

# thirty-one fall-through branches fill the map
I 00000404 00208463 0 0 00 1 31
I 00000480 00000013 0 0 00 1 1
P full_branch_map 1 0 0fffffffff0000047c

# trace off for two instructions, back on restarts
I 00000484 00000013 0 0 00 0 2
I 0000048c 00000013 0 0 00 1 1
P start_reenable 3 0 00000000000000048c

# interrupt into handler at 0x900 and jalr back
I 00000490 00000013 1 1 0b 1 1
I 00000900 00000013 0 0 00 1 1
I 00000904 00008067 0 0 00 1 1
I 00000494 00000013 0 0 00 1 1
P trap_interrupt 3 1 000000002b00000900
P jalr_return 2 0 000000000000000494

# trailing instructions so the return target gets decided
I 00000498 00000013 0 0 00 1 2

//--- verilog.f
src/trace_pkg.sv
src/trace_sampler.sv
src/trace_itype_stage.sv
src/trace_branch_map.sv
src/trace_packet_decider.sv
src/trace_packet_emitter.sv
src/trace_encoder.sv
test/trace_encoder_tb.sv
